// File: hdl/afe_readout_consts.svh
`ifndef AFE_READOUT_CONSTS_SVH
`define AFE_READOUT_CONSTS_SVH

// --------------------------------------------------
// ADC result
// --------------------------------------------------
// SAR result width
`define AFE_SAMPLE_W 16

// --------------------------------------------------
// Analog channels
// --------------------------------------------------
// One enable bit per channel
`define AFE_NUM_CH 8
// Channel number width
`define AFE_CH_IDX_W 3

// --------------------------------------------------
// Sample FIFO
// --------------------------------------------------
`define AFE_FIFO_DEPTH 8
// Pointers wrap naturally at depth
`define AFE_FIFO_PTR_W 3
// Occupancy needs one extra bit to hold a full count
`define AFE_FIFO_CNT_W 4
`define AFE_WMARK_W 4

`endif

// File: hdl/afe_readout_pkg.sv
package afe_readout_pkg;

`include "afe_readout_consts.svh"

    // --------------------------------------------------
    // Plain vectors
    // --------------------------------------------------
    // One ADC conversion result
    typedef logic [`AFE_SAMPLE_W-1:0] adc_word_t;
    // Channel enables and one-hot select
    typedef logic [`AFE_NUM_CH-1:0] ch_mask_t;
    // Channel number
    typedef logic [`AFE_CH_IDX_W-1:0] ch_idx_t;
    // FIFO occupancy, 0 to depth
    typedef logic [`AFE_FIFO_CNT_W-1:0] fifo_cnt_t;
    // Data ready threshold
    typedef logic [`AFE_WMARK_W-1:0] wmark_t;

    // --------------------------------------------------
    // Bundles
    // --------------------------------------------------
    // Tagged sample as stored in the FIFO, 20 bits
    typedef struct packed {
        ch_idx_t   ch;
        logic      last;    // Highest enabled channel of the scan
        adc_word_t result;
    } adc_sample_t;

    // Sticky error bits, also used as clear mask
    typedef struct packed {
        logic overflow;
        logic underflow;
    } status_t;

    // Channel sequencer FSM
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_DISCARD,
        SEQ_SCAN
    } seq_state_t;

endpackage

// File: hdl/channel_sequencer.sv
`include "afe_readout_consts.svh"

module channel_sequencer import afe_readout_pkg::*; (
    input  logic        SAMPLE_CLK,
    input  logic        nrst_sync,
    // Sampling enable level
    input  logic        ensamp,
    // Channel enables, stable while ensamp is high
    input  ch_mask_t    chen,
    // ADC conversion complete
    input  logic        done,
    input  adc_word_t   result,
    // Analog mux select, one-hot
    output ch_mask_t    chsel,
    // Sample strobe towards the FIFO
    output logic        push,
    output adc_sample_t sample
);

    seq_state_t state;
    // Channel being converted right now
    ch_idx_t    cur_ch;
    // DONE taken as a real sample this cycle
    logic       take;

    // --------------------------------------------------
    // Channel mask helpers
    // --------------------------------------------------
    // Lowest enabled channel, zero for an empty mask
    function automatic ch_idx_t lowest_ch(ch_mask_t en);
        ch_idx_t idx;
        idx = '0;
        // Scan downwards so the lowest hit is written last
        for (int i = `AFE_NUM_CH - 1; i >= 0; i--) begin
            if (en[i]) begin
                idx = ch_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // Next enabled channel above cur, else wrap to the lowest
    function automatic ch_idx_t next_ch(ch_mask_t en, ch_idx_t cur);
        ch_idx_t nxt;
        logic    found;
        nxt   = lowest_ch(en);
        found = 1'b0;
        for (int i = 0; i < `AFE_NUM_CH; i++) begin
            if (!found && i > int'(cur) && en[i]) begin
                nxt   = ch_idx_t'(i);
                found = 1'b1;
            end
        end
        return nxt;
    endfunction

    // No enabled channel above cur
    function automatic logic is_last(ch_mask_t en, ch_idx_t cur);
        ch_mask_t above;
        above = en >> cur;
        return (above >> 1) == '0;
    endfunction

    // --------------------------------------------------
    // Sequencer FSM
    // --------------------------------------------------
    // Only a DONE in SCAN with sampling still on makes a sample
    assign take = ensamp && done && (state == SEQ_SCAN);

    always_ff @(posedge SAMPLE_CLK or negedge nrst_sync) begin
        if (!nrst_sync) begin
            state  <= SEQ_IDLE;
            cur_ch <= '0;
        end else if (!ensamp) begin
            // Disable re-arms the startup discard
            state <= SEQ_IDLE;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (chen != '0) begin
                        state  <= SEQ_DISCARD;
                        cur_ch <= lowest_ch(chen);
                    end
                end
                SEQ_DISCARD: begin
                    // First conversion after enable is junk, swallow it
                    if (done) begin
                        state <= SEQ_SCAN;
                    end
                end
                SEQ_SCAN: begin
                    // Select moves on the edge that takes DONE
                    if (done) begin
                        cur_ch <= next_ch(chen, cur_ch);
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Mux select off while idle
    assign chsel = (state == SEQ_IDLE) ? '0 : (ch_mask_t'(1) << cur_ch);

    // --------------------------------------------------
    // Sample output
    // --------------------------------------------------
    always_ff @(posedge SAMPLE_CLK or negedge nrst_sync) begin
        if (!nrst_sync) begin
            push <= 1'b0;
        end else begin
            push <= take;
        end
    end

    // Payload, only meaningful with push
    always_ff @(posedge SAMPLE_CLK) begin
        if (take) begin
            sample.ch     <= cur_ch;
            sample.last   <= is_last(chen, cur_ch);
            sample.result <= result;
        end
    end

endmodule

// File: hdl/sample_fifo.sv
`include "afe_readout_consts.svh"

module sample_fifo import afe_readout_pkg::*; (
    input  logic        SAMPLE_CLK,
    input  logic        nrst_sync,
    // Write side from the sequencer
    input  logic        push,
    input  adc_sample_t wr_sample,
    // Read side from the readout block
    input  logic        pop,
    input  wmark_t      watermark,
    // Oldest entry, valid while not empty
    output adc_sample_t head,
    output logic        empty,
    output logic        data_rdy,
    // Single-cycle error pulses
    output logic        overflow,
    output logic        underflow
);

    // --------------------------------------------------
    // Storage and pointers
    // --------------------------------------------------
    adc_sample_t                mem [`AFE_FIFO_DEPTH];
    logic [`AFE_FIFO_PTR_W-1:0] wr_ptr;
    logic [`AFE_FIFO_PTR_W-1:0] rd_ptr;
    fifo_cnt_t                  count;

    logic full;
    logic do_push;
    logic do_pop;

    assign full  = (count == fifo_cnt_t'(`AFE_FIFO_DEPTH));
    assign empty = (count == '0);

    // Pop frees a slot on a full FIFO, so a same-cycle push still fits
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    // Dropped sample, FIFO left as is
    assign overflow  = push && full && !do_pop;
    // Read with nothing stored
    assign underflow = pop && empty;

    // --------------------------------------------------
    // Control state
    // --------------------------------------------------
    always_ff @(posedge SAMPLE_CLK or negedge nrst_sync) begin
        if (!nrst_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Occupancy only moves when one side acts alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Sample RAM
    always_ff @(posedge SAMPLE_CLK) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_sample;
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    // Show-ahead read port
    assign head = mem[rd_ptr];

    // Watermark of zero still needs one entry
    assign data_rdy = !empty && (count >= fifo_cnt_t'(watermark));

endmodule

// File: hdl/readout_status.sv
module readout_status import afe_readout_pkg::*; (
    input  logic        SAMPLE_CLK,
    input  logic        nrst_sync,
    // External read strobe
    input  logic        rd_req,
    // FIFO read side
    input  adc_sample_t head,
    input  logic        empty,
    input  logic        overflow,
    input  logic        underflow,
    // Masked clear of the sticky bits
    input  logic        status_clr,
    input  status_t     clr_mask,
    output logic        pop,
    output adc_sample_t rd_sample,
    output status_t     status,
    output logic        irq
);

    // Per-bit set and clear requests
    status_t set_bits;
    status_t clr_bits;

    // --------------------------------------------------
    // Read path
    // --------------------------------------------------
    // Every read strobe reaches the FIFO, empty reads flag underflow there
    assign pop = rd_req;

    // Output sample holds over empty reads
    always_ff @(posedge SAMPLE_CLK or negedge nrst_sync) begin
        if (!nrst_sync) begin
            rd_sample <= '0;
        end else if (rd_req && !empty) begin
            rd_sample <= head;
        end
    end

    // --------------------------------------------------
    // Sticky status
    // --------------------------------------------------
    always_comb begin
        set_bits.overflow  = overflow;
        set_bits.underflow = underflow;
        clr_bits.overflow  = status_clr && clr_mask.overflow;
        clr_bits.underflow = status_clr && clr_mask.underflow;
    end

    // New event beats a clear in the same cycle
    always_ff @(posedge SAMPLE_CLK or negedge nrst_sync) begin
        if (!nrst_sync) begin
            status <= '0;
        end else begin
            status.overflow  <= set_bits.overflow
                                || (status.overflow && !clr_bits.overflow);
            status.underflow <= set_bits.underflow
                                || (status.underflow && !clr_bits.underflow);
        end
    end

    // Interrupt while any error is pending
    assign irq = status.overflow || status.underflow;

endmodule

// File: hdl/afe_readout_top.sv
module afe_readout_top import afe_readout_pkg::*; (
    input  logic        SAMPLE_CLK,
    input  logic        nrst_sync,
    // Sampling control levels
    input  logic        ensamp,
    input  ch_mask_t    chen,
    // ADC interface
    input  logic        done,
    input  adc_word_t   result,
    // Readout control
    input  wmark_t      watermark,
    input  logic        rd_req,
    input  logic        status_clr,
    input  status_t     clr_mask,
    output ch_mask_t    chsel,
    output logic        data_rdy,
    output adc_sample_t rd_sample,
    output status_t     status,
    output logic        irq
);

    // Sequencer to FIFO
    logic        push;
    adc_sample_t sample;

    // FIFO to readout
    adc_sample_t head;
    logic        empty;
    logic        overflow;
    logic        underflow;
    logic        pop;

    // --------------------------------------------------
    // Producer
    // --------------------------------------------------
    channel_sequencer channel_sequencer_i (
        .SAMPLE_CLK (SAMPLE_CLK),
        .nrst_sync  (nrst_sync),
        .ensamp     (ensamp),
        .chen       (chen),
        .done       (done),
        .result     (result),
        .chsel      (chsel),
        .push       (push),
        .sample     (sample)
    );

    // --------------------------------------------------
    // Sample buffer
    // --------------------------------------------------
    sample_fifo sample_fifo_i (
        .SAMPLE_CLK (SAMPLE_CLK),
        .nrst_sync  (nrst_sync),
        .push       (push),
        .wr_sample  (sample),
        .pop        (pop),
        .watermark  (watermark),
        .head       (head),
        .empty      (empty),
        .data_rdy   (data_rdy),
        .overflow   (overflow),
        .underflow  (underflow)
    );

    // --------------------------------------------------
    // Consumer and status
    // --------------------------------------------------
    readout_status readout_status_i (
        .SAMPLE_CLK (SAMPLE_CLK),
        .nrst_sync  (nrst_sync),
        .rd_req     (rd_req),
        .head       (head),
        .empty      (empty),
        .overflow   (overflow),
        .underflow  (underflow),
        .status_clr (status_clr),
        .clr_mask   (clr_mask),
        .pop        (pop),
        .rd_sample  (rd_sample),
        .status     (status),
        .irq        (irq)
    );

endmodule

// File: tests/afe_readout_props.sv
`include "afe_readout_consts.svh"

module afe_readout_props import afe_readout_pkg::*; (
    input logic       SAMPLE_CLK,
    input logic       nrst_sync,
    // Sequencer side
    input ch_mask_t   chen,
    input ch_mask_t   chsel,
    input logic       push,
    input seq_state_t state,
    // FIFO side
    input fifo_cnt_t  count
);

    // Tally of failed assertions, read back by the testbench
    int fail_cnt = 0;

    // --------------------------------------------------
    // Sequencer
    // --------------------------------------------------
    // Mux select is off or names exactly one channel
    chsel_onehot: assert property (@(posedge SAMPLE_CLK) disable iff (!nrst_sync)
        $onehot0(chsel))
        else begin
            $error("chsel %b is not one-hot", chsel);
            fail_cnt++;
        end

    // Never select a disabled channel
    chsel_in_chen: assert property (@(posedge SAMPLE_CLK) disable iff (!nrst_sync)
        (chsel & ~chen) == '0)
        else begin
            $error("chsel %b outside chen %b", chsel, chen);
            fail_cnt++;
        end

    // Startup conversion never reaches the FIFO
    no_push_in_discard: assert property (@(posedge SAMPLE_CLK) disable iff (!nrst_sync)
        (state == SEQ_DISCARD) |-> !push)
        else begin
            $error("push seen in SEQ_DISCARD");
            fail_cnt++;
        end

    // --------------------------------------------------
    // FIFO
    // --------------------------------------------------
    count_in_range: assert property (@(posedge SAMPLE_CLK) disable iff (!nrst_sync)
        count <= fifo_cnt_t'(`AFE_FIFO_DEPTH))
        else begin
            $error("FIFO occupancy %0d above depth", count);
            fail_cnt++;
        end

endmodule

// Unused ports of each copy are tied to quiet values
bind channel_sequencer afe_readout_props props_i (
    .SAMPLE_CLK (SAMPLE_CLK),
    .nrst_sync  (nrst_sync),
    .chen       (chen),
    .chsel      (chsel),
    .push       (push),
    .state      (state),
    .count      ('0)
);

bind sample_fifo afe_readout_props props_i (
    .SAMPLE_CLK (SAMPLE_CLK),
    .nrst_sync  (nrst_sync),
    .chen       ('0),
    .chsel      ('0),
    .push       (1'b0),
    .state      (SEQ_IDLE),
    .count      (count)
);

// File: tests/afe_readout_tb.sv
`include "afe_readout_consts.svh"

module afe_readout_tb import afe_readout_pkg::*; ();

    localparam int        SEED        = 32'h693d_4b7b;
    // Marker result for the startup conversion
    localparam adc_word_t DISCARD_RES = 16'hdead;
    // Cycle budget per test
    localparam int T_RESET = 10;
    localparam int T_SEQ   = 120;
    localparam int T_REARM = 40;
    localparam int T_WMARK = 120;
    localparam int T_OVF   = 50;
    localparam int T_UNF   = 20;
    localparam int WATCHDOG = (T_RESET + T_SEQ + T_REARM + T_WMARK + T_OVF + T_UNF) * 10 * 2;

    logic        SAMPLE_CLK;
    logic        nrst_sync;
    logic        ensamp;
    ch_mask_t    chen;
    logic        done;
    adc_word_t   result;
    wmark_t      watermark;
    logic        rd_req;
    logic        status_clr;
    status_t     clr_mask;
    ch_mask_t    chsel;
    logic        data_rdy;
    adc_sample_t rd_sample;
    status_t     status;
    logic        irq;

    // Model of FIFO contents, output register and sticky bits
    adc_sample_t exp_q[$];
    adc_sample_t last_rd;
    adc_sample_t rd_exp;
    int          scan_idx;
    logic        in_discard;
    logic        exp_ovf;
    logic        exp_unf;
    // Bookkeeping
    int rd_issued = 0;
    int rd_checked = 0;
    int errors = 0;
    int cmp_errors = 0;
    int tests = 0;
    int failed = 0;
    int test_errs = 0;

    afe_readout_top afe_readout_top_i (
        .SAMPLE_CLK (SAMPLE_CLK),
        .nrst_sync  (nrst_sync),
        .ensamp     (ensamp),
        .chen       (chen),
        .done       (done),
        .result     (result),
        .watermark  (watermark),
        .rd_req     (rd_req),
        .status_clr (status_clr),
        .clr_mask   (clr_mask),
        .chsel      (chsel),
        .data_rdy   (data_rdy),
        .rd_sample  (rd_sample),
        .status     (status),
        .irq        (irq)
    );

    initial SAMPLE_CLK = 1'b0;
    always #5 SAMPLE_CLK = ~SAMPLE_CLK;

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    // n-th kept sample after enable, ascending through enabled channels
    function automatic adc_sample_t ref_sample(ch_mask_t mask, int n, adc_word_t res);
        int          chans[$];
        adc_sample_t s;
        for (int i = 0; i < `AFE_NUM_CH; i++) begin
            if (mask[i]) begin
                chans.push_back(i);
            end
        end
        s.ch     = ch_idx_t'(chans[n % chans.size()]);
        s.last   = (n % chans.size()) == chans.size() - 1;
        s.result = res;
        return s;
    endfunction

    // Data ready needs at least one entry and the watermark
    function automatic logic rdy_rule(int occ, wmark_t wm);
        return occ != 0 && occ >= int'(wm);
    endfunction

    function automatic adc_word_t rand_result();
        adc_word_t r;
        r = adc_word_t'($urandom());
        if (r == DISCARD_RES) begin
            r = ~r;
        end
        return r;
    endfunction

    function automatic ch_mask_t rand_mask();
        ch_mask_t m;
        m = '0;
        while (m == '0) begin
            m = ch_mask_t'($urandom());
        end
        return m;
    endfunction

    // --------------------------------------------------
    // Driver tasks
    // --------------------------------------------------
    task automatic tick();
        @(posedge SAMPLE_CLK);
        #1;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    // data_rdy, status and irq against the model
    task automatic check_flags();
        logic    exp_rdy;
        status_t exp_st;
        exp_rdy          = rdy_rule(exp_q.size(), watermark);
        exp_st.overflow  = exp_ovf;
        exp_st.underflow = exp_unf;
        if (data_rdy !== exp_rdy) begin
            report_mismatch("data_rdy", 32'(data_rdy), 32'(exp_rdy));
        end
        if (status !== exp_st) begin
            report_mismatch("status", 32'(status), 32'(exp_st));
        end
        if (irq !== (exp_ovf | exp_unf)) begin
            report_mismatch("irq", 32'(irq), 32'(exp_ovf | exp_unf));
        end
    endtask

    // One DONE, then one idle edge so the sample lands in the FIFO
    task automatic convert(input adc_word_t res);
        adc_sample_t s;
        ch_mask_t    exp_sel;
        s       = ref_sample(chen, scan_idx, res);
        exp_sel = ch_mask_t'(1) << s.ch;
        if (chsel !== exp_sel) begin
            report_mismatch("chsel", 32'(chsel), 32'(exp_sel));
        end
        done   = 1'b1;
        result = res;
        tick();
        done = 1'b0;
        tick();
        if (in_discard) begin
            in_discard = 1'b0;
        end else begin
            scan_idx++;
            if (exp_q.size() < `AFE_FIFO_DEPTH) begin
                exp_q.push_back(s);
            end else begin
                exp_ovf = 1'b1;
            end
        end
        check_flags();
    endtask

    // Read strobe, rd_sample itself is checked by the compare process
    task automatic read_sample();
        rd_req = 1'b1;
        tick();
        rd_req = 1'b0;
        if (exp_q.size() == 0) begin
            exp_unf = 1'b1;
        end else begin
            last_rd = exp_q.pop_front();
        end
        rd_exp = last_rd;
        rd_issued++;
        check_flags();
    endtask

    task automatic drain();
        while (exp_q.size() > 0) begin
            read_sample();
        end
    endtask

    // Enable, then feed the startup conversion that must be dropped
    task automatic start_sampling(input ch_mask_t mask);
        chen   = mask;
        ensamp = 1'b1;
        tick();
        scan_idx   = 0;
        in_discard = 1'b1;
        convert(DISCARD_RES);
    endtask

    task automatic stop_sampling();
        ensamp = 1'b0;
        tick();
        if (chsel !== '0) begin
            report_mismatch("chsel", 32'(chsel), 32'(0));
        end
    endtask

    task automatic clear_status(input status_t mask);
        status_clr = 1'b1;
        clr_mask   = mask;
        tick();
        status_clr = 1'b0;
        clr_mask   = '0;
        if (mask.overflow) begin
            exp_ovf = 1'b0;
        end
        if (mask.underflow) begin
            exp_unf = 1'b0;
        end
        check_flags();
    endtask

    // Waits past the falling edge so pending compares are done
    task automatic end_test(input string name);
        int n;
        tick();
        n = errors + cmp_errors - test_errs;
        tests++;
        if (n != 0) begin
            failed++;
        end
        $display("Test %0d %s: %0d error(s)", tests, name, n);
        test_errs = errors + cmp_errors;
    endtask

    // --------------------------------------------------
    // Compare process
    // --------------------------------------------------
    // Falling edge, outputs settled since the read edge
    always @(negedge SAMPLE_CLK) begin
        if (rd_checked != rd_issued) begin
            rd_checked++;
            if (rd_sample !== rd_exp) begin
                cmp_errors++;
                $display("** Error at %0t: rd_sample = %h, expected %h",
                         $time, rd_sample, rd_exp);
            end
            if (rd_sample.result === DISCARD_RES) begin
                cmp_errors++;
                $display("Startup conversion reached rd_sample at %0t", $time);
            end
        end
    end

    initial begin
        #(WATCHDOG);
        $display("Watchdog expired at %0t, tests did not complete", $time);
        $display("** FAIL **");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int assert_fails;
        int total;
        void'($urandom(SEED));
        ensamp     = 1'b0;
        chen       = '0;
        done       = 1'b0;
        result     = '0;
        watermark  = wmark_t'(1);
        rd_req     = 1'b0;
        status_clr = 1'b0;
        clr_mask   = '0;
        last_rd    = '0;
        rd_exp     = '0;
        exp_ovf    = 1'b0;
        exp_unf    = 1'b0;
        scan_idx   = 0;
        in_discard = 1'b0;
        nrst_sync  = 1'b0;
        repeat (2) @(posedge SAMPLE_CLK);
        #1;
        nrst_sync = 1'b1;

        tick();
        if (chsel !== '0) begin
            report_mismatch("chsel", 32'(chsel), 32'(0));
        end
        if (rd_sample !== '0) begin
            report_mismatch("rd_sample", 32'(rd_sample), 32'(0));
        end
        check_flags();
        end_test("reset");

        // Random results with reads mixed in, never above six entries
        start_sampling(rand_mask());
        for (int i = 0; i < 24; i++) begin
            convert(rand_result());
            if (exp_q.size() >= 6 || ($urandom() % 2) == 1) begin
                read_sample();
            end
        end
        drain();
        end_test("sequencing");

        stop_sampling();
        start_sampling(rand_mask());
        for (int i = 0; i < 6; i++) begin
            convert(rand_result());
            read_sample();
        end
        end_test("re-arm");

        // Watermarks 0, 3, 6 and 9
        for (int w = 0; w < 4; w++) begin
            watermark = wmark_t'(w * 3);
            for (int i = 0; i < `AFE_FIFO_DEPTH; i++) begin
                convert(rand_result());
            end
            drain();
        end
        watermark = wmark_t'(1);
        end_test("watermark");

        // Two samples past full get dropped
        for (int i = 0; i < 10; i++) begin
            convert(rand_result());
        end
        drain();
        // Empty read sets underflow so the overflow-only clear has something to keep
        read_sample();
        clear_status(status_t'(2'b10));
        clear_status(status_t'(2'b01));
        end_test("overflow");

        read_sample();
        clear_status(status_t'(2'b11));
        end_test("underflow");

        assert_fails = afe_readout_top_i.channel_sequencer_i.props_i.fail_cnt
                       + afe_readout_top_i.sample_fifo_i.props_i.fail_cnt;
        if (assert_fails != 0) begin
            $display("Bound assertions failed %0d time(s)", assert_fails);
        end
        total = errors + cmp_errors + assert_fails;
        $display("Tests run: %0d, tests with errors: %0d, errors: %0d", tests, failed, total);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: afe_readout.f
+incdir+hdl
hdl/afe_readout_pkg.sv
hdl/channel_sequencer.sv
hdl/sample_fifo.sv
hdl/readout_status.sv
hdl/afe_readout_top.sv
tests/afe_readout_props.sv
tests/afe_readout_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the AFE readout testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module afe_readout_tb \
    -f afe_readout.f \
    --Mdir obj_dir

# Keep running after an assertion error so the testbench can report
out=$(./obj_dir/Vafe_readout_tb +verilator+error+limit+1000) || true
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
    exit 0
else
    exit 1
fi
